// File: alu.f
+incdir+dv
src/aluPkg.sv
src/claAddSub.sv
src/barrelShifter.sv
src/resultSelect.sv
src/alu.sv
dv/aluTb.sv

// File: dv/aluModel.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Expected result from the operation rules
function automatic dataT predictResult(input aluReqT r);
    dataT a;
    dataT b;
    dataT res;

    a = r.operandA;
    b = r.operandB;
    case (r.opcode[2:0])
        3'd0:    res = a + b;
        3'd1:    res = a - b;
        3'd2:    res = a & b;
        3'd3:    res = a | b;
        3'd4:    res = a << r.shiftAmt;
        3'd5:    res = dataT'($signed(a) >>> r.shiftAmt);
        default: res = '0;
    endcase
    return res;
endfunction

// Flags from A, B and opcode bit 0
function automatic aluFlagsT deriveFlags(input aluReqT r);
    dataT     a;
    dataT     b;
    dataT     s;
    dataT     d;
    logic     addOv;
    logic     subOv;
    aluFlagsT f;

    a = r.operandA;
    b = r.operandB;
    s = a + b;
    d = a - b;
    addOv = (a[31] == b[31]) && (s[31] != a[31]);
    subOv = (a[31] != b[31]) && (d[31] != a[31]);

    f.isNotEqual = (a != b);
    f.isLessThan = d[31];                // Raw sign of A minus B
    f.overflow   = r.opcode[0] ? subOv : addOv;
    return f;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;

    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

`endif

// File: dv/aluTb.sv
module aluTb;
    timeunit 1ns;
    timeprecision 1ps;

    import aluPkg::*;

    `include "aluModel.svh"

    localparam int ResetCycles   = 5;
    localparam int NumVectors    = 44;
    localparam int NumRandom     = 200;
    localparam int TimeoutCycles = ResetCycles + NumVectors + NumRandom + 20;

    typedef struct packed {
        logic [OpcodeWidth-1:0] opcode;
        dataT                   operandA;
        dataT                   operandB;
        logic [ShamtWidth-1:0]  shiftAmt;
        dataT                   expResult;
        aluFlagsT               expFlags;   // {isNotEqual, isLessThan, overflow}
    } vecT;

    // opcode, A, B, shiftAmt, expected result, expected flags
    vecT vecTable [NumVectors] = '{
        '{5'd0, 32'h7fff_ffff, 32'h0000_0001, 5'd0,  32'h8000_0000, 3'b101},
        '{5'd0, 32'h8000_0000, 32'h8000_0000, 5'd0,  32'h0000_0000, 3'b001},
        '{5'd0, 32'h0000_0000, 32'h0000_0000, 5'd0,  32'h0000_0000, 3'b000},
        '{5'd0, 32'h0000_1234, 32'h0000_0010, 5'd7,  32'h0000_1244, 3'b100},
        '{5'd0, 32'hffff_ffff, 32'h0000_0001, 5'd0,  32'h0000_0000, 3'b110},
        '{5'd0, 32'h0000_00ff, 32'h0000_0001, 5'd0,  32'h0000_0100, 3'b100},
        '{5'd0, 32'h00ff_ffff, 32'h0000_0001, 5'd0,  32'h0100_0000, 3'b100},
        '{5'd0, 32'h0000_ff00, 32'h0000_0100, 5'd0,  32'h0001_0000, 3'b100},
        '{5'd0, 32'hff00_0000, 32'h0100_0000, 5'd0,  32'h0000_0000, 3'b110},
        '{5'd1, 32'h8000_0000, 32'h0000_0001, 5'd0,  32'h7fff_ffff, 3'b101},  // lt wrong way
        '{5'd1, 32'h7fff_ffff, 32'hffff_ffff, 5'd0,  32'h8000_0000, 3'b111},
        '{5'd1, 32'h0000_0005, 32'h0000_0005, 5'd0,  32'h0000_0000, 3'b000},
        '{5'd1, 32'h0000_0003, 32'h0000_0005, 5'd0,  32'hffff_fffe, 3'b110},
        '{5'd1, 32'h0000_0000, 32'h8000_0000, 5'd0,  32'h8000_0000, 3'b111},
        '{5'd1, 32'h0000_0100, 32'h0000_0001, 5'd0,  32'h0000_00ff, 3'b100},
        '{5'd2, 32'hffff_ffff, 32'hffff_ffff, 5'd0,  32'hffff_ffff, 3'b000},
        '{5'd2, 32'haaaa_aaaa, 32'h5555_5555, 5'd0,  32'h0000_0000, 3'b100},
        '{5'd2, 32'h1234_5678, 32'h0000_0000, 5'd0,  32'h0000_0000, 3'b100},
        '{5'd2, 32'h1234_5679, 32'h1234_5678, 5'd0,  32'h1234_5678, 3'b100},
        '{5'd3, 32'haaaa_aaaa, 32'h5555_5555, 5'd0,  32'hffff_ffff, 3'b101},
        '{5'd3, 32'h0000_0000, 32'h0000_0000, 5'd0,  32'h0000_0000, 3'b000},
        '{5'd3, 32'hf0f0_f0f0, 32'h0f0f_0f0f, 5'd0,  32'hffff_ffff, 3'b110},
        '{5'd4, 32'h0000_0001, 32'h0000_0000, 5'd0,  32'h0000_0001, 3'b100},
        '{5'd4, 32'hffff_0000, 32'h0000_0000, 5'd0,  32'hffff_0000, 3'b110},
        '{5'd4, 32'h8000_0001, 32'h0000_0000, 5'd1,  32'h0000_0002, 3'b110},
        '{5'd4, 32'h4000_0001, 32'h0000_0000, 5'd1,  32'h8000_0002, 3'b100},
        '{5'd4, 32'h0000_abcd, 32'h0000_0000, 5'd16, 32'habcd_0000, 3'b100},
        '{5'd4, 32'h8000_1234, 32'h0000_0000, 5'd16, 32'h1234_0000, 3'b110},
        '{5'd4, 32'h0000_0001, 32'h0000_0000, 5'd31, 32'h8000_0000, 3'b100},
        '{5'd4, 32'hffff_ffff, 32'h0000_0000, 5'd31, 32'h8000_0000, 3'b110},
        '{5'd5, 32'h8000_0000, 32'h0000_0000, 5'd0,  32'h8000_0000, 3'b110},
        '{5'd5, 32'h7654_3210, 32'h0000_0000, 5'd0,  32'h7654_3210, 3'b100},
        '{5'd5, 32'h8000_0000, 32'h0000_0000, 5'd1,  32'hc000_0000, 3'b110},
        '{5'd5, 32'h4000_0000, 32'h0000_0000, 5'd1,  32'h2000_0000, 3'b100},
        '{5'd5, 32'h8000_abcd, 32'h0000_0000, 5'd16, 32'hffff_8000, 3'b110},
        '{5'd5, 32'h7654_3210, 32'h0000_0000, 5'd16, 32'h0000_7654, 3'b100},
        '{5'd5, 32'h7fff_ffff, 32'h0000_0000, 5'd31, 32'h0000_0000, 3'b100},
        '{5'd5, 32'h8000_0000, 32'h0000_0000, 5'd31, 32'hffff_ffff, 3'b110},
        '{5'd6, 32'h1234_5678, 32'h1234_5678, 5'd0,  32'h0000_0000, 3'b000},
        '{5'd7, 32'h7fff_ffff, 32'hffff_ffff, 5'd0,  32'h0000_0000, 3'b111},
        '{5'b11000, 32'h7fff_ffff, 32'h0000_0001, 5'd0,  32'h8000_0000, 3'b101},
        '{5'b01001, 32'h0000_0003, 32'h0000_0005, 5'd0,  32'hffff_fffe, 3'b110},
        '{5'b10100, 32'h0000_0001, 32'h0000_0000, 5'd16, 32'h0001_0000, 3'b100},
        '{5'b11110, 32'hffff_ffff, 32'h0000_0001, 5'd0,  32'h0000_0000, 3'b110}
    };

    logic        clock;
    aluReqT      req;
    dataT        result;
    aluFlagsT    flags;
    int          cycleCount;
    int          checkCount;
    int          errorCount;
    logic [31:0] rngState;

    alu DUT (
        .req    (req),
        .result (result),
        .flags  (flags)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    // Run limit counted in rising edges
    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > TimeoutCycles) begin
            $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic checkOutputs(input string tag, input dataT expResult,
                                input aluFlagsT expFlags, output int bad);
        bad = 0;
        checkCount = checkCount + 1;
        if (result !== expResult) begin
            $display("error: %s result got %h expected %h", tag, result, expResult);
            bad = 1;
        end
        if (flags.isNotEqual !== expFlags.isNotEqual) begin
            $display("error: %s isNotEqual got %h expected %h", tag,
                     flags.isNotEqual, expFlags.isNotEqual);
            bad = 1;
        end
        if (flags.isLessThan !== expFlags.isLessThan) begin
            $display("error: %s isLessThan got %h expected %h", tag,
                     flags.isLessThan, expFlags.isLessThan);
            bad = 1;
        end
        if (flags.overflow !== expFlags.overflow) begin
            $display("error: %s overflow got %h expected %h", tag,
                     flags.overflow, expFlags.overflow);
            bad = 1;
        end
        errorCount = errorCount + bad;
    endtask

    initial begin
        int bad;

        req        = '0;
        cycleCount = 0;
        checkCount = 0;
        errorCount = 0;
        rngState   = 32'hcce2_31e1;

        while (cycleCount < ResetCycles) @(negedge clock);   // No checks here

        for (int i = 0; i < NumVectors; i++) begin
            @(posedge clock);
            #5;
            req.operandA = vecTable[i].operandA;
            req.operandB = vecTable[i].operandB;
            req.opcode   = vecTable[i].opcode;
            req.shiftAmt = vecTable[i].shiftAmt;
            @(negedge clock);
            checkOutputs($sformatf("vector %0d", i), vecTable[i].expResult,
                         vecTable[i].expFlags, bad);
            $display("vector %0d opcode %b: %s", i, vecTable[i].opcode,
                     (bad != 0) ? "mismatch" : "ok");
        end

        for (int n = 0; n < NumRandom; n++) begin
            @(posedge clock);
            #5;
            rngState     = xorshift32(rngState);
            req.operandA = rngState;
            rngState     = xorshift32(rngState);
            req.operandB = rngState;
            rngState     = xorshift32(rngState);
            req.opcode   = rngState[4:0];
            req.shiftAmt = rngState[9:5];
            if (rngState[12:10] == 3'd0)
                req.operandB = req.operandA;     // Equal operands now and then
            @(negedge clock);
            checkOutputs($sformatf("random %0d", n), predictResult(req), deriveFlags(req), bad);
            $display("random %0d opcode %b: %s", n, req.opcode,
                     (bad != 0) ? "mismatch" : "ok");
        end

        $display("summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f alu.f --top-module aluTb -o aluSim

./obj_dir/aluSim > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
    echo "run.sh: simulation reported a failure"
    exit 1
fi

if ! grep -q "Test OK" sim.log; then
    echo "run.sh: simulation ended without a verdict"
    exit 1
fi

echo "run.sh: simulation passed"
exit 0

// File: src/alu.sv
module alu (
    input  aluPkg::aluReqT   req,
    output aluPkg::dataT     result,
    output aluPkg::aluFlagsT flags
);
    import aluPkg::*;

    dataT sum;
    dataT difference;
    dataT shiftedLeft;
    dataT shiftedRight;

    claAddSub uAddSub (
        .operandA   (req.operandA),
        .operandB   (req.operandB),
        .sum        (sum),
        .difference (difference)
    );

    barrelShifter uShifter (
        .operandA     (req.operandA),
        .shiftAmt     (req.shiftAmt),
        .shiftedLeft  (shiftedLeft),
        .shiftedRight (shiftedRight)
    );

    // Only this unit looks at the opcode
    resultSelect uSelect (
        .req          (req),
        .sum          (sum),
        .difference   (difference),
        .shiftedLeft  (shiftedLeft),
        .shiftedRight (shiftedRight),
        .result       (result),
        .flags        (flags)
    );

endmodule

// File: src/aluPkg.sv
package aluPkg;

    localparam int DataWidth   = 32;
    localparam int ShamtWidth  = 5;
    localparam int OpcodeWidth = 5;

    // Adder is split into ripple blocks joined by a lookahead network
    localparam int BlockWidth = 8;
    localparam int NumBlocks  = DataWidth / BlockWidth;

    typedef logic [DataWidth-1:0] dataT;

    // Operation in the low three opcode bits
    typedef enum logic [2:0] {
        OpAdd = 3'd0,
        OpSub = 3'd1,
        OpAnd = 3'd2,
        OpOr  = 3'd3,
        OpSll = 3'd4,
        OpSra = 3'd5
    } aluOpT;

    typedef struct packed {
        dataT                   operandA;
        dataT                   operandB;
        logic [OpcodeWidth-1:0] opcode;     // Upper two bits unused
        logic [ShamtWidth-1:0]  shiftAmt;
    } aluReqT;

    typedef struct packed {
        logic isNotEqual;
        logic isLessThan;
        logic overflow;
    } aluFlagsT;

endpackage

// File: src/barrelShifter.sv
module barrelShifter (
    input  aluPkg::dataT                  operandA,
    input  logic [aluPkg::ShamtWidth-1:0] shiftAmt,
    output aluPkg::dataT                  shiftedLeft,
    output aluPkg::dataT                  shiftedRight
);
    import aluPkg::*;

    // Entry k is the word after stages 0 to k-1
    dataT leftStage  [0:ShamtWidth];
    dataT rightStage [0:ShamtWidth];
    logic signBit;

    assign signBit       = operandA[DataWidth-1];
    assign leftStage[0]  = operandA;
    assign rightStage[0] = operandA;

    // Stage k moves the word by 2^k when shiftAmt[k] is set
    for (genvar k = 0; k < ShamtWidth; k++) begin : gStage
        assign leftStage[k+1] = shiftAmt[k]
            ? {leftStage[k][DataWidth-1-2**k:0], {(2**k){1'b0}}}
            : leftStage[k];

        // Fill from the original sign, not from the stage input
        assign rightStage[k+1] = shiftAmt[k]
            ? {{(2**k){signBit}}, rightStage[k][DataWidth-1:2**k]}
            : rightStage[k];
    end

    assign shiftedLeft  = leftStage[ShamtWidth];
    assign shiftedRight = rightStage[ShamtWidth];

endmodule

// File: src/claAddSub.sv
module claAddSub (
    input  aluPkg::dataT operandA,
    input  aluPkg::dataT operandB,
    output aluPkg::dataT sum,
    output aluPkg::dataT difference
);
    import aluPkg::*;

    dataT invertedB;

    // One adder path of ripple blocks with group G/P and a lookahead carry per block
    function automatic dataT claAdd(input dataT a, input dataT b, input logic carryIn);
        logic [NumBlocks-1:0] groupGen;
        logic [NumBlocks-1:0] groupProp;
        logic [NumBlocks-1:0] blockCarry;
        logic                 carryTerm;
        logic                 propChain;
        logic                 ripple;
        int                   idx;
        dataT                 bitGen;
        dataT                 bitProp;
        dataT                 s;

        bitGen  = a & b;
        bitProp = a | b;

        // Group terms scanned from the low bit of each block upwards
        for (int j = 0; j < NumBlocks; j++) begin
            groupGen[j]  = 1'b0;
            groupProp[j] = 1'b1;
            for (int i = 0; i < BlockWidth; i++) begin
                idx          = j * BlockWidth + i;
                groupGen[j]  = bitGen[idx] | (bitProp[idx] & groupGen[j]);
                groupProp[j] = groupProp[j] & bitProp[idx];
            end
        end

        // Sum of products over the lower groups and the carry-in
        blockCarry[0] = carryIn;
        for (int j = 1; j < NumBlocks; j++) begin
            carryTerm = 1'b0;
            propChain = 1'b1;
            for (int k = j - 1; k >= 0; k--) begin
                carryTerm = carryTerm | (propChain & groupGen[k]);
                propChain = propChain & groupProp[k];
            end
            blockCarry[j] = carryTerm | (propChain & carryIn);
        end

        // Ripple inside each block
        for (int j = 0; j < NumBlocks; j++) begin
            ripple = blockCarry[j];
            for (int i = 0; i < BlockWidth; i++) begin
                idx    = j * BlockWidth + i;
                s[idx] = a[idx] ^ b[idx] ^ ripple;
                ripple = bitGen[idx] | (bitProp[idx] & ripple);
            end
        end

        return s;
    endfunction

    assign invertedB = ~operandB;

    assign sum        = claAdd(operandA, operandB, 1'b0);
    assign difference = claAdd(operandA, invertedB, 1'b1);    // A + ~B + 1

endmodule

// File: src/resultSelect.sv
module resultSelect (
    input  aluPkg::aluReqT   req,
    input  aluPkg::dataT     sum,
    input  aluPkg::dataT     difference,
    input  aluPkg::dataT     shiftedLeft,
    input  aluPkg::dataT     shiftedRight,
    output aluPkg::dataT     result,
    output aluPkg::aluFlagsT flags
);
    import aluPkg::*;

    aluOpT op;
    dataT  andWord;
    dataT  orWord;
    logic  signA;
    logic  signB;
    logic  signSum;
    logic  signDiff;
    logic  addOverflow;
    logic  subOverflow;

    assign op = aluOpT'(req.opcode[2:0]);   // Upper opcode bits ignored

    assign andWord = req.operandA & req.operandB;
    assign orWord  = req.operandA | req.operandB;

    always_comb begin
        case (op)
            OpAdd:   result = sum;
            OpSub:   result = difference;
            OpAnd:   result = andWord;
            OpOr:    result = orWord;
            OpSll:   result = shiftedLeft;
            OpSra:   result = shiftedRight;
            default: result = '0;            // Codes 6 and 7
        endcase
    end

    assign signA    = req.operandA[DataWidth-1];
    assign signB    = req.operandB[DataWidth-1];
    assign signSum  = sum[DataWidth-1];
    assign signDiff = difference[DataWidth-1];

    // Same-sign operands whose sum flips sign
    assign addOverflow = (signA == signB) && (signSum != signA);
    // Mixed-sign operands whose difference leaves the sign of A
    assign subOverflow = (signA != signB) && (signDiff != signA);

    // Chosen by opcode bit 0 whatever the operation
    assign flags.overflow = req.opcode[0] ? subOverflow : addOverflow;

    assign flags.isLessThan = signDiff;      // No overflow correction
    assign flags.isNotEqual = |(req.operandA ^ req.operandB);

endmodule
